//--- design/bilinear_pipe.sv
`timescale 1ns/1ps

module bilinear_pipe (
	input  logic               clk,
	input  logic               frm_resetn,
	input  logic               i_valid,
	input  scaler_pkg::phase_t i_fx,
	input  scaler_pkg::phase_t i_fy,
	input  logic               i_user,
	input  logic               i_last,
	input  logic               i_eof,
	input  logic               i_rows_ready,
	input  scaler_pkg::pixel_t i_top0,
	input  scaler_pkg::pixel_t i_top1,
	input  scaler_pkg::pixel_t i_bot0,
	input  scaler_pkg::pixel_t i_bot1,
	input  logic               i_out_ready,
	output logic               o_ready,
	output logic               o_rd_en,
	output logic               o_out_valid,
	output logic               o_out_user,
	output logic               o_out_last,
	output logic               o_out_eof,
	output scaler_pkg::pixel_t o_out_data
);
	import scaler_pkg::*;

	logic   pipe_en;
	logic   s0_valid, s0_user, s0_last, s0_eof;
	phase_t s0_fx, s0_fy;
	logic   s1_valid, s1_user, s1_last, s1_eof;
	phase_t s1_fy;
	pixel_t s1_top, s1_bot;

	// weights 4-f and f, truncated.
	function automatic pixel_t interp(input phase_t f, input pixel_t a, input pixel_t b);
		logic [9:0] sum;
		sum = 10'(a) * 10'(3'd4 - f) + 10'(b) * 10'(f);
		return sum[9:2];
	endfunction

	assign pipe_en = ~o_out_valid | i_out_ready;
	assign o_ready = i_rows_ready & pipe_en;
	assign o_rd_en = i_valid & o_ready;  // bank data arrives with stage 0.

	always_ff @(posedge clk) begin
		if (!frm_resetn) begin
			s0_valid    <= 1'b0;
			s1_valid    <= 1'b0;
			o_out_valid <= 1'b0;
		end else if (pipe_en) begin
			s0_valid    <= o_rd_en;
			s1_valid    <= s0_valid;
			o_out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pipe_en) begin
			s0_fx   <= i_fx;
			s0_fy   <= i_fy;
			s0_user <= i_user;
			s0_last <= i_last;
			s0_eof  <= i_eof;

			s1_top  <= interp(s0_fx, i_top0, i_top1);
			s1_bot  <= interp(s0_fx, i_bot0, i_bot1);
			s1_fy   <= s0_fy;
			s1_user <= s0_user;
			s1_last <= s0_last;
			s1_eof  <= s0_eof;

			o_out_data <= interp(s1_fy, s1_top, s1_bot);
			o_out_user <= s1_user;
			o_out_last <= s1_last;
			o_out_eof  <= s1_eof;
		end
	end

endmodule

//--- design/coord_walker.sv
`timescale 1ns/1ps

module coord_walker (
	input  logic               clk,
	input  logic               frm_resetn,
	input  logic               i_en,
	input  logic               i_load_x,
	input  logic               i_load_y,
	input  scaler_pkg::step_t  i_step,
	input  scaler_pkg::dim_t   i_s_width,
	input  scaler_pkg::dim_t   i_s_height,
	input  scaler_pkg::dim_t   i_m_width,
	input  scaler_pkg::dim_t   i_m_height,
	input  logic               i_ready,
	output logic               o_valid,
	output logic               o_user,
	output logic               o_last,
	output logic               o_eof,
	output scaler_pkg::dim_t   o_x0,
	output scaler_pkg::dim_t   o_x1,
	output scaler_pkg::dim_t   o_y0,
	output scaler_pkg::dim_t   o_y1,
	output scaler_pkg::phase_t o_fx,
	output scaler_pkg::phase_t o_fy
);
	import scaler_pkg::*;

	step_t step_x;
	step_t step_y;
	acc_t  acc_x;
	acc_t  acc_y;
	dim_t  dst_col;
	dim_t  dst_row;
	logic  fin;
	logic  adv;

	assign o_valid = i_en & ~fin;
	assign adv     = o_valid & i_ready;

	assign o_user = (dst_col == '0) && (dst_row == '0);
	assign o_last = (dst_col == i_m_width - 1'b1);
	assign o_eof  = o_last && (dst_row == i_m_height - 1'b1);

	// integer part sits above the quarter phase and the fraction.
	assign o_x0 = acc_x[FRAC_BITS + 2 +: $bits(dim_t)];
	assign o_y0 = acc_y[FRAC_BITS + 2 +: $bits(dim_t)];
	assign o_fx = acc_x[FRAC_BITS +: $bits(phase_t)];
	assign o_fy = acc_y[FRAC_BITS +: $bits(phase_t)];

	assign o_x1 = (o_x0 >= i_s_width - 1'b1) ? o_x0 : o_x0 + 1'b1;  // clamp at the edge.
	assign o_y1 = (o_y0 >= i_s_height - 1'b1) ? o_y0 : o_y0 + 1'b1;

	always_ff @(posedge clk) begin
		if (i_load_x)
			step_x <= i_step;
		if (i_load_y)
			step_y <= i_step;
	end

	always_ff @(posedge clk) begin
		if (!frm_resetn) begin
			acc_x   <= '0;
			acc_y   <= '0;
			dst_col <= '0;
			dst_row <= '0;
			fin     <= 1'b0;
		end else if (adv) begin
			if (o_last) begin
				acc_x   <= '0;
				dst_col <= '0;
				acc_y   <= acc_y + acc_t'(step_y);
				dst_row <= dst_row + 1'b1;
			end else begin
				acc_x   <= acc_x + acc_t'(step_x);
				dst_col <= dst_col + 1'b1;
			end
			if (o_eof)
				fin <= 1'b1; // walk complete until the next frame.
		end
	end

endmodule

//--- design/frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl (
	input  logic clk,
	input  logic frm_resetn,
	input  logic i_fsync,
	input  logic i_div_done,
	input  logic i_frame_done,
	output logic o_div_start,
	output logic o_div_sel_y,
	output logic o_walk_en,
	output logic o_busy
);
	import scaler_pkg::*;

	scaler_state_t state;

	assign o_div_sel_y = (state == ST_DIV_Y); // also steers the second done to the y step.
	assign o_walk_en   = (state == ST_RUN);

	always_ff @(posedge clk) begin
		if (!frm_resetn) begin
			state       <= ST_IDLE;
			o_div_start <= 1'b0;
			o_busy      <= 1'b0;
		end else begin
			o_div_start <= 1'b0;
			if (i_fsync) begin
				state       <= ST_DIV_X; // a new frame aborts whatever is running.
				o_div_start <= 1'b1;
				o_busy      <= 1'b1;
			end else begin
				case (state)
				ST_DIV_X: begin
					if (i_div_done) begin
						state       <= ST_DIV_Y;
						o_div_start <= 1'b1;
					end
				end
				ST_DIV_Y: begin
					if (i_div_done)
						state <= ST_RUN;
				end
				ST_RUN: begin
					if (i_frame_done) begin // last output beat taken.
						state  <= ST_DRAIN;
						o_busy <= 1'b0;
					end
				end
				ST_DRAIN: state <= ST_IDLE;
				default:  state <= ST_IDLE;
				endcase
			end
		end
	end

	a_no_div_in_run: assert property (@(posedge clk) disable iff (!frm_resetn)
		(state == ST_RUN) |-> !(o_div_start || i_div_done));

endmodule

//--- design/line_buffer_bank.sv
`timescale 1ns/1ps

module line_buffer_bank (
	input  logic               clk,
	input  logic               frm_resetn,
	input  logic               i_s_valid,
	input  logic               i_s_user,
	input  logic               i_s_last,
	input  scaler_pkg::pixel_t i_s_data,
	input  scaler_pkg::dim_t   i_row_lo,
	input  scaler_pkg::dim_t   i_row_hi,
	input  logic               i_rd_en,
	input  scaler_pkg::dim_t   i_rd_col0,
	input  scaler_pkg::dim_t   i_rd_col1,
	output logic               o_s_ready,
	output logic               o_rows_ready,
	output scaler_pkg::pixel_t o_top0,
	output scaler_pkg::pixel_t o_top1,
	output scaler_pkg::pixel_t o_bot0,
	output scaler_pkg::pixel_t o_bot1
);
	import scaler_pkg::*;

	pixel_t line_mem [LINE_NUM][LINE_DEPTH];

	dim_t  wr_col;
	dim_t  wr_addr;
	dim_t  row_cnt;     // complete rows received.
	dim_t  rel_cnt;     // rows below this are free.
	dim_t  row_cnt_nxt;
	dim_t  rel_cnt_nxt;
	slot_t wr_slot;
	slot_t slot_lo;
	slot_t slot_hi;
	logic  wr_en;

	assign wr_en   = i_s_valid & o_s_ready;
	assign wr_addr = i_s_user ? '0 : wr_col; // first pixel of a frame resyncs the column.
	assign wr_slot = row_cnt[1:0];
	assign slot_lo = i_row_lo[1:0];
	assign slot_hi = i_row_hi[1:0];

	assign o_rows_ready = (row_cnt > i_row_hi);

	always_comb begin
		row_cnt_nxt = row_cnt;
		if (wr_en && i_s_last)
			row_cnt_nxt = row_cnt + 1'b1;
		rel_cnt_nxt = rel_cnt;
		if (i_row_lo > rel_cnt)
			rel_cnt_nxt = i_row_lo;
		if (rel_cnt_nxt > row_cnt_nxt)
			rel_cnt_nxt = row_cnt_nxt; // rows skipped by the walker free up as they land.
	end

	always_ff @(posedge clk) begin
		if (!frm_resetn) begin
			wr_col    <= '0;
			row_cnt   <= '0;
			rel_cnt   <= '0;
			o_s_ready <= 1'b0;
		end else begin
			if (wr_en)
				wr_col <= i_s_last ? '0 : wr_addr + 1'b1;
			row_cnt   <= row_cnt_nxt;
			rel_cnt   <= rel_cnt_nxt;
			o_s_ready <= ((row_cnt_nxt - rel_cnt_nxt) < dim_t'(LINE_NUM));
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			line_mem[wr_slot][wr_addr] <= i_s_data;
		if (i_rd_en) begin
			o_top0 <= line_mem[slot_lo][i_rd_col0];
			o_top1 <= line_mem[slot_lo][i_rd_col1];
			o_bot0 <= line_mem[slot_hi][i_rd_col0];
			o_bot1 <= line_mem[slot_hi][i_rd_col1];
		end
	end

	// a row the walker still reads is never overwritten.
	a_slot_free: assert property (@(posedge clk) disable iff (!frm_resetn)
		wr_en |-> ({1'b0, row_cnt} < {1'b0, i_row_lo} + 11'(LINE_NUM)));

endmodule

//--- design/output_relay.sv
`timescale 1ns/1ps

module output_relay (
	input  logic               clk,
	input  logic               frm_resetn,
	input  logic               i_valid,
	input  logic               i_user,
	input  logic               i_last,
	input  logic               i_eof,
	input  scaler_pkg::pixel_t i_data,
	input  logic               i_ready,
	output logic               o_ready,
	output logic               o_valid,
	output logic               o_user,
	output logic               o_last,
	output logic               o_eof,
	output scaler_pkg::pixel_t o_data
);
	import scaler_pkg::*;

	logic   skid_valid;
	logic   skid_user, skid_last, skid_eof;
	pixel_t skid_data;

	assign o_ready = ~skid_valid; // straight from a flop.

	always_ff @(posedge clk) begin
		if (!frm_resetn) begin
			o_valid    <= 1'b0;
			skid_valid <= 1'b0;
		end else if (skid_valid) begin
			if (i_ready)
				skid_valid <= 1'b0;
		end else if (!o_valid || i_ready) begin
			o_valid <= i_valid;
		end else if (i_valid) begin
			skid_valid <= 1'b1;  // output held, park the beat.
		end
	end

	always_ff @(posedge clk) begin
		if (skid_valid) begin
			if (i_ready) begin
				o_data <= skid_data;
				o_user <= skid_user;
				o_last <= skid_last;
				o_eof  <= skid_eof;
			end
		end else if (!o_valid || i_ready) begin
			o_data <= i_data;
			o_user <= i_user;
			o_last <= i_last;
			o_eof  <= i_eof;
		end else begin
			skid_data <= i_data;
			skid_user <= i_user;
			skid_last <= i_last;
			skid_eof  <= i_eof;
		end
	end

	a_hold_stable: assert property (@(posedge clk) disable iff (!frm_resetn)
		(o_valid && !i_ready) |=> (o_valid && $stable({o_data, o_user, o_last, o_eof})));

endmodule

//--- design/scaler_pkg.sv
package scaler_pkg;

	typedef logic [7:0]  pixel_t;  // single-channel pixel.
	typedef logic [9:0]  dim_t;    // width, height, column or row.
	typedef logic [1:0]  phase_t;  // quarter-pixel phase.
	typedef logic [13:0] step_t;   // quarter-pixels per output pixel, 8 fractional bits.
	typedef logic [21:0] acc_t;    // walker position, same scaling as step_t.
	typedef logic [1:0]  slot_t;   // line buffer index.

	localparam int LINE_NUM   = 4;
	localparam int FRAC_BITS  = 8;
	localparam int LINE_DEPTH = 1024;

	// per-frame sequence: two divisions, then the walk, then a settle cycle.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DIV_X,
		ST_DIV_Y,
		ST_RUN,
		ST_DRAIN
	} scaler_state_t;

endpackage

//--- design/step_divider.sv
`timescale 1ns/1ps

module step_divider (
	input  logic              clk,
	input  logic              frm_resetn,
	input  logic              i_start,
	input  scaler_pkg::dim_t  i_num,
	input  scaler_pkg::dim_t  i_den,
	output logic              o_done,
	output scaler_pkg::step_t o_quot
);
	import scaler_pkg::*;

	logic        busy;
	logic [3:0]  iter_cnt;
	dim_t        rem;
	dim_t        den_q;
	step_t       dvd;   // dividend bits still to be shifted in.
	logic [10:0] trial;
	logic        take;

	assign trial = {rem, dvd[$bits(step_t)-1]};
	assign take  = (trial >= {1'b0, den_q});

	always_ff @(posedge clk) begin
		if (!frm_resetn) begin
			busy     <= 1'b0;
			iter_cnt <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy     <= 1'b1;
				iter_cnt <= 4'($bits(step_t));
			end else if (busy) begin
				iter_cnt <= iter_cnt - 1'b1;
				if (iter_cnt == 4'd1) begin
					busy   <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	// dividend is num * 1024; its upper six bits seed the remainder.
	always_ff @(posedge clk) begin
		if (i_start) begin
			rem   <= dim_t'(i_num[9:4]);
			dvd   <= {i_num[3:0], 10'd0};
			den_q <= i_den;
		end else if (busy) begin
			rem    <= take ? dim_t'(trial - {1'b0, den_q}) : trial[9:0];
			dvd    <= dvd << 1;
			o_quot <= {o_quot[$bits(step_t)-2:0], take};
		end
	end

	a_den_nonzero: assert property (@(posedge clk) disable iff (!frm_resetn)
		i_start |-> (i_den != '0));

endmodule

//--- design/video_scaler_top.sv
`timescale 1ns/1ps

module video_scaler_top (
	input  logic               clk,
	input  logic               frm_resetn,
	input  logic               i_fsync,
	input  scaler_pkg::dim_t   i_s_width,
	input  scaler_pkg::dim_t   i_s_height,
	input  scaler_pkg::dim_t   i_m_width,
	input  scaler_pkg::dim_t   i_m_height,
	output logic               o_busy,
	input  logic               i_s_valid,
	input  scaler_pkg::pixel_t i_s_data,
	input  logic               i_s_user,
	input  logic               i_s_last,
	output logic               o_s_ready,
	output logic               o_m_valid,
	output scaler_pkg::pixel_t o_m_data,
	output logic               o_m_user,
	output logic               o_m_last,
	input  logic               i_m_ready
);
	import scaler_pkg::*;

	logic   frame_resetn;
	logic   div_start, div_sel_y, div_done;
	logic   walk_en, frame_done;
	logic   load_x, load_y;
	dim_t   div_num, div_den;
	step_t  div_quot;
	logic   walk_valid, walk_ready, walk_user, walk_last, walk_eof;
	dim_t   x0, x1, y0, y1;
	phase_t fx, fy;
	logic   rows_ready, rd_en;
	pixel_t top0, top1, bot0, bot1;
	logic   pipe_valid, pipe_user, pipe_last, pipe_eof;
	pixel_t pipe_data;
	logic   relay_ready, m_eof;

	// the datapath restarts on every frame sync.
	assign frame_resetn = frm_resetn & ~i_fsync;

	assign div_num    = div_sel_y ? i_s_height : i_s_width;
	assign div_den    = div_sel_y ? i_m_height : i_m_width;
	assign load_x     = div_done & ~div_sel_y;
	assign load_y     = div_done & div_sel_y;
	assign frame_done = o_m_valid & i_m_ready & m_eof;

	frame_ctrl u_ctrl (
		.clk          (clk),
		.frm_resetn   (frm_resetn),
		.i_fsync      (i_fsync),
		.i_div_done   (div_done),
		.i_frame_done (frame_done),
		.o_div_start  (div_start),
		.o_div_sel_y  (div_sel_y),
		.o_walk_en    (walk_en),
		.o_busy       (o_busy)
	);

	step_divider u_div (
		.clk        (clk),
		.frm_resetn (frame_resetn),
		.i_start    (div_start),
		.i_num      (div_num),
		.i_den      (div_den),
		.o_done     (div_done),
		.o_quot     (div_quot)
	);

	coord_walker u_walk (
		.clk        (clk),
		.frm_resetn (frame_resetn),
		.i_en       (walk_en),
		.i_load_x   (load_x),
		.i_load_y   (load_y),
		.i_step     (div_quot),
		.i_s_width  (i_s_width),
		.i_s_height (i_s_height),
		.i_m_width  (i_m_width),
		.i_m_height (i_m_height),
		.i_ready    (walk_ready),
		.o_valid    (walk_valid),
		.o_user     (walk_user),
		.o_last     (walk_last),
		.o_eof      (walk_eof),
		.o_x0       (x0),
		.o_x1       (x1),
		.o_y0       (y0),
		.o_y1       (y1),
		.o_fx       (fx),
		.o_fy       (fy)
	);

	line_buffer_bank u_bank (
		.clk          (clk),
		.frm_resetn   (frame_resetn),
		.i_s_valid    (i_s_valid),
		.i_s_user     (i_s_user),
		.i_s_last     (i_s_last),
		.i_s_data     (i_s_data),
		.i_row_lo     (y0),
		.i_row_hi     (y1),
		.i_rd_en      (rd_en),
		.i_rd_col0    (x0),
		.i_rd_col1    (x1),
		.o_s_ready    (o_s_ready),
		.o_rows_ready (rows_ready),
		.o_top0       (top0),
		.o_top1       (top1),
		.o_bot0       (bot0),
		.o_bot1       (bot1)
	);

	bilinear_pipe u_pipe (
		.clk          (clk),
		.frm_resetn   (frame_resetn),
		.i_valid      (walk_valid),
		.i_fx         (fx),
		.i_fy         (fy),
		.i_user       (walk_user),
		.i_last       (walk_last),
		.i_eof        (walk_eof),
		.i_rows_ready (rows_ready),
		.i_top0       (top0),
		.i_top1       (top1),
		.i_bot0       (bot0),
		.i_bot1       (bot1),
		.i_out_ready  (relay_ready),
		.o_ready      (walk_ready),
		.o_rd_en      (rd_en),
		.o_out_valid  (pipe_valid),
		.o_out_user   (pipe_user),
		.o_out_last   (pipe_last),
		.o_out_eof    (pipe_eof),
		.o_out_data   (pipe_data)
	);

	output_relay u_relay (
		.clk        (clk),
		.frm_resetn (frame_resetn),
		.i_valid    (pipe_valid),
		.i_user     (pipe_user),
		.i_last     (pipe_last),
		.i_eof      (pipe_eof),
		.i_data     (pipe_data),
		.i_ready    (i_m_ready),
		.o_ready    (relay_ready),
		.o_valid    (o_m_valid),
		.o_user     (o_m_user),
		.o_last     (o_m_last),
		.o_eof      (m_eof),
		.o_data     (o_m_data)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f vlog.f --top-module scaler_tb -o Vscaler_tb

out=$(./obj_dir/Vscaler_tb 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "SIMULATION PASSED"

//--- verification/scaler_tb.sv
`timescale 1ns/1ps

module scaler_tb;
	import scaler_pkg::*;

	localparam int N_FRAMES     = 10;
	localparam int ABORT_AT     = 9;   // reset lands between these frames.
	localparam int WIDE_FRAME   = 8;
	localparam int ABORT_CYCLES = 200;
	localparam int SRC_MAX      = 8192;

	logic   clk;
	logic   frm_resetn;
	logic   i_fsync;
	dim_t   i_s_width, i_s_height, i_m_width, i_m_height;
	logic   o_busy;
	logic   i_s_valid, i_s_user, i_s_last, o_s_ready;
	pixel_t i_s_data;
	logic   o_m_valid, o_m_user, o_m_last, i_m_ready;
	pixel_t o_m_data;

	pixel_t src_pix [SRC_MAX];
	dim_t   fr_sw [N_FRAMES];
	dim_t   fr_sh [N_FRAMES];
	dim_t   fr_mw [N_FRAMES];
	dim_t   fr_mh [N_FRAMES];
	int     s_w, s_h, m_w, m_h, step_x, step_y;
	int     wd_cycles = 0;

	video_scaler_top dut0 (
		.clk        (clk),
		.frm_resetn (frm_resetn),
		.i_fsync    (i_fsync),
		.i_s_width  (i_s_width),
		.i_s_height (i_s_height),
		.i_m_width  (i_m_width),
		.i_m_height (i_m_height),
		.o_busy     (o_busy),
		.i_s_valid  (i_s_valid),
		.i_s_data   (i_s_data),
		.i_s_user   (i_s_user),
		.i_s_last   (i_s_last),
		.o_s_ready  (o_s_ready),
		.o_m_valid  (o_m_valid),
		.o_m_data   (o_m_data),
		.o_m_user   (o_m_user),
		.o_m_last   (o_m_last),
		.i_m_ready  (i_m_ready)
	);

	always #10 clk = ~clk;

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "pixel mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %0b, got %0b", $time, name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_count(input string name, input dim_t exp, input dim_t act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	// kind 0 keeps the size, 1 enlarges up to 4x, 2 shrinks up to 2x, 3 picks 1 or 2.
	task automatic pick_axis(input int kind, input int lo, input int hi,
			output dim_t s, output dim_t d);
		int mode;
		int a;
		int b;
		mode = (kind == 3) ? 1 + int'($urandom % 2) : kind;
		if (mode == 0) begin
			a = $urandom_range(hi, lo);
			b = a;
		end else if (mode == 1) begin
			a = $urandom_range(hi, lo);
			b = $urandom_range((4 * a > 1023) ? 1023 : 4 * a, a);
		end else begin
			b = $urandom_range(hi, lo);
			a = $urandom_range((2 * b > 1023) ? 1023 : 2 * b, b);
		end
		s = dim_t'(a);
		d = dim_t'(b);
	endtask

	task automatic plan_frames();
		int   kind;
		int   lim;
		dim_t sw, sh, mw, mh;
		for (int f = 0; f < N_FRAMES; f++) begin
			if (f == WIDE_FRAME) begin
				pick_axis(3, 512, 1023, sw, mw);
				pick_axis(3, 2, 3, sh, mh);
			end else begin
				kind = (f < 8) ? f / 2 : 3;
				lim  = (kind == 0) ? 40 : (kind == 1) ? 20 : (kind == 2) ? 32 : 24;
				pick_axis(kind, 2, lim, sw, mw);
				pick_axis(kind, 2, lim, sh, mh);
			end
			fr_sw[f] = sw;
			fr_sh[f] = sh;
			fr_mw[f] = mw;
			fr_mh[f] = mh;
		end
	endtask

	function automatic int blend(input int f, input int a, input int b);
		return (a * (4 - f) + b * f) / 4;
	endfunction

	function automatic int src_at(input int x, input int y);
		return int'(src_pix[y * s_w + x]);
	endfunction

	// destination pixel (i, j) from the step, position and blend rules.
	function automatic pixel_t model_pixel(input int i, input int j);
		int px;
		int py;
		int x0;
		int x1;
		int y0;
		int y1;
		int top;
		int bot;
		px  = (i * step_x) / 256;
		py  = (j * step_y) / 256;
		x0  = px / 4;
		y0  = py / 4;
		x1  = (x0 + 1 < s_w) ? x0 + 1 : s_w - 1;
		y1  = (y0 + 1 < s_h) ? y0 + 1 : s_h - 1;
		top = blend(px % 4, src_at(x0, y0), src_at(x1, y0));
		bot = blend(px % 4, src_at(x0, y1), src_at(x1, y1));
		return pixel_t'(blend(py % 4, top, bot));
	endfunction

	task automatic start_frame(input dim_t sw, input dim_t sh, input dim_t mw, input dim_t mh);
		i_s_width  <= sw;
		i_s_height <= sh;
		i_m_width  <= mw;
		i_m_height <= mh;
		i_fsync    <= 1'b1;
		@(posedge clk);
		i_fsync <= 1'b0;
		@(posedge clk);
		check_flag("o_busy", 1'b1, o_busy);
	endtask

	task automatic feed_source();
		int idx;
		idx = 0;
		while (idx < s_w * s_h) begin
			i_s_valid <= ($urandom_range(3, 0) != 0);
			i_s_data  <= src_pix[idx];
			i_s_user  <= (idx == 0);
			i_s_last  <= ((idx % s_w) == s_w - 1);
			@(posedge clk);
			if (i_s_valid && o_s_ready)
				idx++;
		end
		i_s_valid <= 1'b0;
	endtask

	task automatic collect_output();
		dim_t col;
		dim_t row;
		logic ended;
		col   = '0;
		row   = '0;
		ended = 1'b0;
		while (row < m_h && !ended) begin
			i_m_ready <= ($urandom_range(3, 0) != 0);
			@(posedge clk);
			if (o_m_valid && i_m_ready) begin
				check_pixel("o_m_data", model_pixel(col, row), o_m_data);
				check_flag("o_m_user", (col == 0 && row == 0), o_m_user);
				if (o_m_last)
					check_count("o_m row length", dim_t'(m_w), col + 1'b1);
				check_flag("o_m_last", (col == m_w - 1), o_m_last);
				if (col == m_w - 1) begin
					col = '0;
					row = row + 1'b1;
				end else begin
					col = col + 1'b1;
				end
				if (row == m_h)
					check_flag("o_busy", 1'b1, o_busy); // still busy at the final beat.
			end else if (!o_busy) begin
				ended = 1'b1;
			end
		end
		check_count("o_m row count", dim_t'(m_h), row);
		i_m_ready <= 1'b1;
		@(posedge clk);
		check_flag("o_busy", 1'b0, o_busy);
		repeat (4) begin
			@(posedge clk);
			check_flag("o_m_valid", 1'b0, o_m_valid); // nothing after the last beat.
		end
	endtask

	task automatic run_frame(input int f);
		s_w    = fr_sw[f];
		s_h    = fr_sh[f];
		m_w    = fr_mw[f];
		m_h    = fr_mh[f];
		step_x = (1024 * s_w) / m_w;
		step_y = (1024 * s_h) / m_h;
		for (int n = 0; n < s_w * s_h; n++)
			src_pix[n] = pixel_t'($urandom);
		start_frame(fr_sw[f], fr_sh[f], fr_mw[f], fr_mh[f]);
		fork
			feed_source();
			collect_output();
		join
	endtask

	// upscaled frame cut short by a reset, outputs are not checked.
	task automatic abort_frame();
		dim_t sw, sh, mw, mh;
		int   idx;
		pick_axis(1, 20, 24, sw, mw);
		pick_axis(1, 20, 24, sh, mh);
		start_frame(sw, sh, mw, mh);
		idx = 0;
		repeat (ABORT_CYCLES) begin
			i_s_valid <= ($urandom % 2 == 0);
			i_s_data  <= pixel_t'($urandom);
			i_s_user  <= (idx == 0);
			i_s_last  <= ((idx % sw) == sw - 1);
			i_m_ready <= ($urandom % 2 == 0);
			@(posedge clk);
			if (i_s_valid && o_s_ready)
				idx++;
		end
		check_flag("o_busy", 1'b1, o_busy);
		frm_resetn <= 1'b0;
		i_s_valid  <= 1'b0;
		i_m_ready  <= 1'b0;
		repeat (4) @(posedge clk);
		check_flag("o_m_valid", 1'b0, o_m_valid);
		check_flag("o_s_ready", 1'b0, o_s_ready);
		check_flag("o_busy", 1'b0, o_busy);
		frm_resetn <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	initial begin : watchdog
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", wd_cycles);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int budget;
		clk        = 1'b0;
		frm_resetn <= 1'b0;
		i_fsync    <= 1'b0;
		i_s_width  <= 10'd2;
		i_s_height <= 10'd2;
		i_m_width  <= 10'd2;
		i_m_height <= 10'd2;
		i_s_valid  <= 1'b0;
		i_s_data   <= '0;
		i_s_user   <= 1'b0;
		i_s_last   <= 1'b0;
		i_m_ready  <= 1'b0;
		void'($urandom(32'hb167));
		plan_frames();
		budget = 2200 + ABORT_CYCLES;
		for (int f = 0; f < N_FRAMES; f++)
			budget += 40 * fr_mw[f] * fr_mh[f] + 2000;
		wd_cycles = budget;
		repeat (10) @(posedge clk);
		frm_resetn <= 1'b1;
		repeat (4) @(posedge clk);
		for (int f = 0; f < ABORT_AT; f++)
			run_frame(f);
		abort_frame();
		for (int f = ABORT_AT; f < N_FRAMES; f++)
			run_frame(f);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- vlog.f
design/scaler_pkg.sv
design/frame_ctrl.sv
design/step_divider.sv
design/coord_walker.sv
design/line_buffer_bank.sv
design/bilinear_pipe.sv
design/output_relay.sv
design/video_scaler_top.sv
verification/scaler_tb.sv
